//--- source/dcache_cfg_pkg.sv
package dcache_cfg_pkg;

    localparam int WAYS = 2;
    localparam int SETS = 16;
    localparam int LINE_WORDS = 4;
    localparam int BYTES_PER_WORD = 4;

    localparam int WAY_BITS = $clog2(WAYS);
    localparam int INDEX_BITS = $clog2(SETS);
    localparam int OFFSET_BITS = $clog2(LINE_WORDS);
    localparam int ALIGN_BITS = $clog2(BYTES_PER_WORD);
    localparam int TAG_BITS = 32 - INDEX_BITS - OFFSET_BITS - ALIGN_BITS;

    typedef logic [8*BYTES_PER_WORD-1:0] word_t;
    // any bit set marks a store
    typedef logic [BYTES_PER_WORD-1:0] strobe_t;
    typedef logic [WAY_BITS-1:0] way_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [OFFSET_BITS-1:0] offset_t;
    typedef logic [TAG_BITS-1:0] tag_t;

    typedef struct packed {
        tag_t                  tag;
        index_t                index;
        offset_t               offset;
        logic [ALIGN_BITS-1:0] align;
    } addr_t;

endpackage

//--- source/dcache_ctrl_pkg.sv
package dcache_ctrl_pkg;

    // one beat per line word
    localparam int BURST_LEN = dcache_cfg_pkg::LINE_WORDS;

    // counter needs one extra step for the read latency during eviction
    localparam int BEAT_BITS = $clog2(BURST_LEN) + 1;
    localparam logic [BEAT_BITS-1:0] READ_STEPS = BEAT_BITS'(BURST_LEN);

    typedef enum logic [1:0] {
        IDLE,
        EVICT_READ,
        WRITEBACK,
        FETCH
    } miss_state_t;

endpackage

//--- source/dcache_miss_if.sv
interface dcache_miss_if
    import dcache_cfg_pkg::*;
();

    logic   miss;
    index_t index;
    tag_t   tag;
    way_t   victim_way;
    tag_t   victim_tag;
    logic   victim_dirty;
    // last refill beat written
    logic   fill_done;

    modport lookup (
        output miss, index, tag, victim_way, victim_tag, victim_dirty,
        input  fill_done
    );

    modport ctrl (
        input  miss, index, tag, victim_way, victim_tag, victim_dirty,
        output fill_done
    );

endinterface

//--- source/dcache_ram_port_if.sv
interface dcache_ram_port_if
    import dcache_cfg_pkg::*;
();

    logic    en;
    way_t    way;
    index_t  index;
    offset_t offset;
    strobe_t strobe;
    word_t   wdata;
    word_t   rdata;

    modport requester (
        output en, way, index, offset, strobe, wdata,
        input  rdata
    );

    modport ram (
        input  en, way, index, offset, strobe, wdata,
        output rdata
    );

endinterface

//--- source/dcache_data_ram.sv
module dcache_data_ram
    import dcache_cfg_pkg::*;
(
    input logic            clk,
    dcache_ram_port_if.ram a,
    dcache_ram_port_if.ram b
);

    word_t mem [WAYS][SETS][LINE_WORDS];

    function automatic word_t merge(word_t old_w, word_t new_w, strobe_t strb);
        word_t res;
        res = old_w;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (strb[i]) begin
                res[8*i +: 8] = new_w[8*i +: 8];
            end
        end
        return res;
    endfunction

    // read-first on both ports
    always_ff @(posedge clk) begin
        if (a.en) begin
            a.rdata <= mem[a.way][a.index][a.offset];
            if (|a.strobe) begin
                mem[a.way][a.index][a.offset] <= merge(mem[a.way][a.index][a.offset],
                                                       a.wdata, a.strobe);
            end
        end
        if (b.en) begin
            b.rdata <= mem[b.way][b.index][b.offset];
            if (|b.strobe) begin
                mem[b.way][b.index][b.offset] <= merge(mem[b.way][b.index][b.offset],
                                                       b.wdata, b.strobe);
            end
        end
    end

    // hit path and refill never target one word together
    assert property (@(posedge clk)
        !(a.en && b.en && |a.strobe && |b.strobe && a.way == b.way
          && a.index == b.index && a.offset == b.offset));

endmodule

//--- source/dcache_lookup.sv
module dcache_lookup
    import dcache_cfg_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    req_valid,
    input  addr_t   req_addr,
    input  strobe_t req_strobe,
    input  word_t   req_wdata,
    output logic    addr_ok,
    output logic    data_ok,
    dcache_miss_if.lookup        miss,
    dcache_ram_port_if.requester ram
);

    // held request
    logic    held_valid;
    addr_t   held_addr;
    strobe_t held_strobe;
    word_t   held_wdata;

    // meta arrays
    logic [WAYS-1:0][SETS-1:0] line_valid;
    logic [WAYS-1:0][SETS-1:0] line_dirty;
    way_t [SETS-1:0]           plru;
    tag_t                      tag_ram [WAYS][SETS];

    logic [WAYS-1:0] hit_vec;
    logic            hit;
    way_t            hit_way;
    way_t            victim;
    index_t          idx;
    logic            data_ok_q;

    assign idx = held_addr.index;
    assign victim = plru[idx];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = held_valid && line_valid[w][idx] && tag_ram[w][idx] == held_addr.tag;
            if (hit_vec[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |hit_vec;
    assign addr_ok = !held_valid || hit;
    assign data_ok = data_ok_q;

    always_ff @(posedge clk) begin
        if (resetn) begin
            held_valid <= 1'b0;
            data_ok_q <= 1'b0;
            line_valid <= '0;
            line_dirty <= '0;
            plru <= '0;
        end else begin
            data_ok_q <= hit;
            if (addr_ok) begin
                held_valid <= req_valid;
            end
            if (hit) begin
                plru[idx] <= ~hit_way;
                if (|held_strobe) begin
                    line_dirty[hit_way][idx] <= 1'b1;
                end
            end
            if (miss.fill_done) begin
                line_valid[victim][idx] <= 1'b1;
                line_dirty[victim][idx] <= 1'b0;
                plru[idx] <= ~victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok && req_valid) begin
            held_addr <= req_addr;
            held_strobe <= req_strobe;
            held_wdata <= req_wdata;
        end
        if (miss.fill_done) begin
            tag_ram[victim][idx] <= held_addr.tag;
        end
    end

    assign miss.miss = held_valid && !hit;
    assign miss.index = idx;
    assign miss.tag = held_addr.tag;
    assign miss.victim_way = victim;
    assign miss.victim_tag = tag_ram[victim][idx];
    assign miss.victim_dirty = line_dirty[victim][idx] && line_valid[victim][idx];

    // hit access on port a
    assign ram.en = hit;
    assign ram.way = hit_way;
    assign ram.index = idx;
    assign ram.offset = held_addr.offset;
    assign ram.strobe = held_strobe;
    assign ram.wdata = held_wdata;

    // refill must never install a tag already present in the other way
    assert property (@(posedge clk) disable iff (resetn) held_valid |-> $onehot0(hit_vec));

endmodule

//--- source/dcache_miss_ctrl.sv
module dcache_miss_ctrl
    import dcache_cfg_pkg::*, dcache_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    dcache_miss_if.ctrl          miss,
    dcache_ram_port_if.requester ram,
    output logic  mem_valid,
    output logic  mem_is_write,
    output addr_t mem_addr,
    output word_t mem_wdata,
    input  logic  mem_ready,
    input  word_t mem_rdata,
    input  logic  mem_last
);

    miss_state_t          state;
    logic [BEAT_BITS-1:0] cnt;
    offset_t              cnt_ofs;
    logic                 beat_done;
    word_t                line_buf [LINE_WORDS];

    assign cnt_ofs = offset_t'(cnt);
    assign beat_done = mem_valid && mem_ready;

    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= IDLE;
            cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (miss.miss) begin
                        state <= miss.victim_dirty ? EVICT_READ : FETCH;
                    end
                end
                EVICT_READ: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == READ_STEPS) begin
                        state <= WRITEBACK;
                        cnt <= '0;
                    end
                end
                WRITEBACK, FETCH: begin
                    if (beat_done) begin
                        cnt <= cnt + 1'b1;
                        if (mem_last) begin
                            state <= (state == WRITEBACK) ? FETCH : IDLE;
                            cnt <= '0;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // victim word arrives one cycle after its read
    always_ff @(posedge clk) begin
        if (state == EVICT_READ && cnt != '0) begin
            line_buf[offset_t'(cnt - 1'b1)] <= ram.rdata;
        end
    end

    // port b reads the victim, then writes refill beats
    assign ram.en = (state == EVICT_READ && cnt != READ_STEPS) || (state == FETCH && beat_done);
    assign ram.way = miss.victim_way;
    assign ram.index = miss.index;
    assign ram.offset = cnt_ofs;
    assign ram.strobe = {BYTES_PER_WORD{state == FETCH}};
    assign ram.wdata = mem_rdata;

    assign miss.fill_done = state == FETCH && beat_done && mem_last;

    assign mem_valid = state == WRITEBACK || state == FETCH;
    assign mem_is_write = state == WRITEBACK;
    assign mem_wdata = line_buf[cnt_ofs];

    // line address with offset 0
    always_comb begin
        mem_addr = '0;
        mem_addr.tag = (state == WRITEBACK) ? miss.victim_tag : miss.tag;
        mem_addr.index = miss.index;
    end

    // bus in use only while lookup holds a miss
    assert property (@(posedge clk) disable iff (resetn)
        mem_valid |-> miss.miss);

    // bus request held steady through a stall
    assert property (@(posedge clk) disable iff (resetn)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr)
            && $stable(mem_is_write) && $stable(mem_wdata));

endmodule

//--- source/dcache_top.sv
module dcache_top
    import dcache_cfg_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,

    input  logic    req_valid,
    input  addr_t   req_addr,
    input  strobe_t req_strobe,
    input  word_t   req_wdata,
    output logic    addr_ok,
    output logic    data_ok,
    output word_t   rdata,

    output logic    mem_valid,
    output logic    mem_is_write,
    output addr_t   mem_addr,
    output word_t   mem_wdata,
    input  logic    mem_ready,
    input  word_t   mem_rdata,
    input  logic    mem_last
);

    dcache_miss_if     miss_bus ();
    dcache_ram_port_if port_a ();
    dcache_ram_port_if port_b ();

    // load data comes straight off the hit port
    assign rdata = port_a.rdata;

    dcache_lookup u_lookup (
        .clk        (clk),
        .resetn     (resetn),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_strobe (req_strobe),
        .req_wdata  (req_wdata),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .miss       (miss_bus.lookup),
        .ram        (port_a.requester)
    );

    dcache_miss_ctrl u_miss_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .miss         (miss_bus.ctrl),
        .ram          (port_b.requester),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata),
        .mem_last     (mem_last)
    );

    dcache_data_ram u_data_ram (
        .clk (clk),
        .a   (port_a.ram),
        .b   (port_b.ram)
    );

endmodule

//--- tests/mem_model.sv
module mem_model
    import dcache_cfg_pkg::*;
(
    input  logic  clk,
    input  logic  mem_valid,
    input  logic  mem_is_write,
    input  addr_t mem_addr,
    input  word_t mem_wdata,
    output logic  mem_ready,
    output word_t mem_rdata,
    output logic  mem_last
);

    localparam int MEM_WORDS = 1024;

    word_t      words [MEM_WORDS];
    logic [1:0] beat;
    logic       take;

    // bursts always start at offset 0, so the beat picks the word
    assign mem_rdata = words[{mem_addr[11:4], beat}];
    assign mem_last = beat == 2'd3;

    task automatic set_word(input logic [9:0] i, input word_t w);
        words[i] = w;
    endtask

    function automatic word_t get_word(input logic [9:0] i);
        return words[i];
    endfunction

    initial begin
        mem_ready = 1'b0;
        beat = 2'd0;
        forever begin
            // handshake is stable mid cycle
            @(negedge clk);
            take = mem_valid && mem_ready;
            if (take && mem_is_write) begin
                words[{mem_addr[11:4], beat}] = mem_wdata;
            end
            @(posedge clk);
            #1;
            if (take) begin
                beat = beat + 2'd1;
            end
            // stall roughly one cycle in four
            mem_ready = ($urandom % 4) != 0;
        end
    end

endmodule

//--- tests/dcache_tb.sv
module dcache_tb
    import dcache_cfg_pkg::*;
();

    localparam int TIMEOUT = 500;
    localparam int MEM_WORDS = 1024;
    localparam int RAND_OPS = 80;

    logic    clk;
    logic    resetn;
    logic    req_valid;
    addr_t   req_addr;
    strobe_t req_strobe;
    word_t   req_wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    mem_valid;
    logic    mem_is_write;
    addr_t   mem_addr;
    word_t   mem_wdata;
    logic    mem_ready;
    word_t   mem_rdata;
    logic    mem_last;

    word_t golden [MEM_WORDS];

    // directed table
    string   t_name[$];
    addr_t   t_addr[$];
    strobe_t t_strobe[$];
    word_t   t_wdata[$];
    logic    t_b2b[$];
    int      t_bursts[$];
    addr_t   t_wb[$];

    // responses still owed, in request order
    string exp_name[$];
    logic  exp_load[$];
    word_t exp_data[$];

    // first beat of every memory burst
    addr_t burst_addr[$];
    logic  burst_write[$];
    logic  in_burst;

    dcache_top uut (.*);

    mem_model u_mem (
        .clk          (clk),
        .mem_valid    (mem_valid),
        .mem_is_write (mem_is_write),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_ready    (mem_ready),
        .mem_rdata    (mem_rdata),
        .mem_last     (mem_last)
    );

    always #20 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("FAIL %s expected %08h actual %08h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("FAIL %s expected %08h actual %08h", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_error($sformatf("FAIL %s expected %0b actual %0b", name, exp, act));
        end
    endtask

    task automatic add_entry(input string name, input addr_t addr, input strobe_t strb,
                             input word_t wdata, input logic b2b, input int bursts,
                             input addr_t wb);
        t_name.push_back(name);
        t_addr.push_back(addr);
        t_strobe.push_back(strb);
        t_wdata.push_back(wdata);
        t_b2b.push_back(b2b);
        t_bursts.push_back(bursts);
        t_wb.push_back(wb);
    endtask

    // called a little after a rising edge; returns likewise
    task automatic issue_request(input string name, input addr_t addr, input strobe_t strb,
                                 input word_t wdata);
        int         waited;
        logic [9:0] gi;
        waited = 0;
        gi = addr[11:2];
        req_valid = 1'b1;
        req_addr = addr;
        req_strobe = strb;
        req_wdata = wdata;
        while (!addr_ok) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                stop_with_error($sformatf("timed out waiting for addr_ok on %s", name));
            end
        end
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (strb[b]) begin
                golden[gi][8*b +: 8] = wdata[8*b +: 8];
            end
        end
        exp_name.push_back(name);
        exp_load.push_back(strb == '0);
        exp_data.push_back(golden[gi]);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_responses();
        int waited;
        waited = 0;
        while (exp_name.size() != 0) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                stop_with_error($sformatf("timed out waiting for data_ok, %0d responses missing",
                                          exp_name.size()));
            end
        end
    endtask

    task automatic check_bursts(input int i);
        addr_t      line;
        int         last;
        logic [9:0] wi;
        line = t_addr[i];
        line.offset = '0;
        line.align = '0;
        if (burst_addr.size() != t_bursts[i]) begin
            stop_with_error($sformatf("%s caused %0d memory bursts instead of %0d",
                                      t_name[i], burst_addr.size(), t_bursts[i]));
        end
        if (t_bursts[i] == 2) begin
            check_flag({t_name[i], "_wb_write"}, 1'b1, burst_write[0]);
            check_addr({t_name[i], "_wb_addr"}, t_wb[i], burst_addr[0]);
            // written-back line must match the golden copy
            for (int w = 0; w < LINE_WORDS; w++) begin
                wi = t_wb[i][11:2] + 10'(w);
                check_word($sformatf("%s_mem_%0d", t_name[i], w), golden[wi],
                           u_mem.get_word(wi));
            end
        end
        if (t_bursts[i] > 0) begin
            last = t_bursts[i] - 1;
            check_flag({t_name[i], "_fetch_write"}, 1'b0, burst_write[last]);
            check_addr({t_name[i], "_fetch_addr"}, line, burst_addr[last]);
        end
        burst_addr.delete();
        burst_write.delete();
    endtask

    // responses checked mid cycle
    always @(negedge clk) begin
        if (!resetn && data_ok) begin
            if (exp_name.size() == 0) begin
                stop_with_error("data_ok arrived with no request outstanding");
            end
            if (exp_load[0]) begin
                check_word(exp_name[0], exp_data[0], rdata);
            end
            exp_name.delete(0);
            exp_load.delete(0);
            exp_data.delete(0);
        end
    end

    always @(negedge clk) begin
        if (!resetn && mem_valid && !in_burst) begin
            burst_addr.push_back(mem_addr);
            burst_write.push_back(mem_is_write);
        end
        in_burst = !resetn && mem_valid && !(mem_ready && mem_last);
    end

    initial begin
        addr_t   a;
        strobe_t s;
        clk = 1'b0;
        resetn = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_strobe = '0;
        req_wdata = '0;
        in_burst = 1'b0;
        void'($urandom(32'h32f0_ff58));
        for (int i = 0; i < MEM_WORDS; i++) begin
            golden[i] = $urandom;
            u_mem.set_word(10'(i), golden[i]);
        end

        // set 1: cold miss, byte merges, back-to-back hits
        add_entry("cold_load", 32'h014, 4'b0000, 32'h0, 1'b0, 1, '0);
        add_entry("store_byte0", 32'h014, 4'b0001, 32'h0000_00a5, 1'b0, 0, '0);
        add_entry("load_byte0", 32'h014, 4'b0000, 32'h0, 1'b0, 0, '0);
        add_entry("store_upper", 32'h018, 4'b1100, 32'hbeef_0000, 1'b1, 0, '0);
        add_entry("load_upper", 32'h018, 4'b0000, 32'h0, 1'b1, 0, '0);
        add_entry("store_mid", 32'h01c, 4'b0110, 32'h00c3_3c00, 1'b1, 0, '0);
        add_entry("load_mid", 32'h01c, 4'b0000, 32'h0, 1'b0, 0, '0);
        // set 3: lines A, B, C, D use tags 1 to 4
        add_entry("load_a", 32'h134, 4'b0000, 32'h0, 1'b0, 1, '0);
        add_entry("load_b", 32'h238, 4'b0000, 32'h0, 1'b0, 1, '0);
        add_entry("touch_a", 32'h13c, 4'b0000, 32'h0, 1'b0, 0, '0);
        add_entry("load_c", 32'h330, 4'b0000, 32'h0, 1'b0, 1, '0);
        add_entry("hit_a", 32'h130, 4'b0000, 32'h0, 1'b0, 0, '0);
        add_entry("store_c", 32'h334, 4'b1010, 32'h5a00_a500, 1'b0, 0, '0);
        add_entry("store_a", 32'h130, 4'b0011, 32'h0000_77e1, 1'b0, 0, '0);
        add_entry("load_d", 32'h434, 4'b0000, 32'h0, 1'b0, 2, 32'h330);
        add_entry("reload_c", 32'h334, 4'b0000, 32'h0, 1'b0, 2, 32'h130);
        add_entry("reload_a", 32'h130, 4'b0000, 32'h0, 1'b0, 1, '0);

        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b0;

        for (int i = 0; i < t_name.size(); i++) begin
            issue_request(t_name[i], t_addr[i], t_strobe[i], t_wdata[i]);
            if (!t_b2b[i]) begin
                wait_responses();
                check_bursts(i);
            end
        end

        // random traffic over tags 0 to 3, issued as fast as addr_ok allows
        for (int n = 0; n < RAND_OPS; n++) begin
            a = '0;
            a[9:2] = 8'($urandom);
            s = ($urandom % 2 == 0) ? 4'($urandom) : 4'b0000;
            issue_request($sformatf("rand_%0d", n), a, s, $urandom);
        end
        wait_responses();

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- filelist.f
source/dcache_cfg_pkg.sv
source/dcache_ctrl_pkg.sv
source/dcache_miss_if.sv
source/dcache_ram_port_if.sv
source/dcache_data_ram.sv
source/dcache_lookup.sv
source/dcache_miss_ctrl.sv
source/dcache_top.sv
tests/mem_model.sv
tests/dcache_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f filelist.f \
        --top-module dcache_tb -Mdir obj_dir -o dcache_sim; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/dcache_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Finished with no errors"; then
    exit 0
fi
exit 1
